// ==== design/axis_pkg.sv ====
`default_nettype none

package axis_pkg;

  localparam int axis_data_w = 8; // Data field width of every beat.

  typedef struct packed {
    logic [axis_data_w-1:0] data;
    logic                   last;
    logic                   user; // Error flag on the last beat.
  } axis_in_t;

  typedef struct packed {
    logic [axis_data_w-1:0] data;
    logic                   last;
    logic                   src; // Ingress port the frame came from.
  } axis_out_t;

  typedef struct packed {
    logic [axis_data_w-1:0] data;
    logic                   last;
  } fifo_beat_t;

endpackage

`default_nettype wire

// ==== design/mux_pkg.sv ====
`default_nettype none

package mux_pkg;

  localparam int stat_w = 16; // Width of each frame counter.

  typedef enum logic {
    arb_idle,
    arb_busy
  } arb_state_t;

  typedef struct packed {
    logic [stat_w-1:0] committed;
    logic [stat_w-1:0] dropped;
  } port_stats_t;

endpackage

`default_nettype wire

// ==== design/axis_frame_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module axis_frame_fifo import axis_pkg::*; #(
  parameter int ADDR_WIDTH = 3,
  parameter int DATA_WIDTH = axis_data_w
) (
  input  logic       clk,
  input  logic       rst,
  input  axis_in_t   in_beat,
  input  logic       in_valid,
  output logic       in_ready,
  output fifo_beat_t fifo_beat,
  output logic       fifo_valid,
  input  logic       fifo_ready,
  output logic       commit,
  output logic       drop
);

  logic [DATA_WIDTH:0] mem [2**ADDR_WIDTH];
  logic [ADDR_WIDTH:0] wr_ptr;     // End of the last committed frame.
  logic [ADDR_WIDTH:0] wr_ptr_cur; // Speculative write position.
  logic [ADDR_WIDTH:0] rd_ptr;
  logic [DATA_WIDTH:0] out_q;
  logic                out_valid_q;
  logic                dropping;
  logic                full;
  logic                empty;
  logic                write;
  logic                store;
  logic                read;

  assign in_ready = 1'b1; // Overflowing frames are dropped instead.
  assign write    = in_valid && in_ready;

  // Full counts the partial frame too, so it compares against the reader.
  assign full  = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                 (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
  assign empty = (wr_ptr == rd_ptr); // Only committed beats are visible.
  assign store = write && !full && !dropping;
  assign read  = (fifo_ready || !out_valid_q) && !empty;

  assign fifo_beat  = '{data: out_q[DATA_WIDTH:1], last: out_q[0]};
  assign fifo_valid = out_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      dropping   <= 1'b0;
      commit     <= 1'b0;
      drop       <= 1'b0;
    end else begin
      commit <= 1'b0;
      drop   <= 1'b0;
      if (write) begin
        if (full || dropping) begin
          dropping <= !in_beat.last; // Discard the rest of this frame.
          if (in_beat.last) begin
            wr_ptr_cur <= wr_ptr;
            drop       <= 1'b1;
          end
        end else if (in_beat.last && in_beat.user) begin
          wr_ptr_cur <= wr_ptr; // Roll back a bad frame.
          drop       <= 1'b1;
        end else begin
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
          if (in_beat.last) begin
            wr_ptr <= wr_ptr_cur + 1'b1;
            commit <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= {in_beat.data, in_beat.last};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr      <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (fifo_ready || !out_valid_q) begin
        out_valid_q <= !empty; // Output register refills when taken.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      out_q <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

endmodule

`default_nettype wire

// ==== design/frame_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_arbiter import axis_pkg::*, mux_pkg::*; #(
  parameter int DATA_WIDTH = axis_data_w
) (
  input  logic       clk,
  input  logic       rst,
  input  fifo_beat_t fifo_beat [2],
  input  logic       fifo_valid [2],
  output logic       fifo_ready [2],
  output axis_out_t  out_beat,
  output logic       out_valid,
  input  logic       out_ready
);

  arb_state_t            state;
  logic                  served;    // Port granted most recently.
  logic                  next_port;
  logic                  sel;
  logic [DATA_WIDTH-1:0] sel_data;
  logic                  sel_last;
  logic                  xfer_last;

  // The other port wins if it has a frame, else the same port again.
  assign next_port = fifo_valid[~served] ? ~served : served;
  assign sel       = (state == arb_busy) ? served : next_port;

  assign sel_data  = fifo_beat[sel].data;
  assign sel_last  = fifo_beat[sel].last;
  assign out_valid = fifo_valid[sel];
  assign out_beat  = '{data: sel_data, last: sel_last, src: sel};
  assign xfer_last = out_valid && out_ready && sel_last;

  always_comb begin
    fifo_ready[0] = out_ready && (sel == 1'b0);
    fifo_ready[1] = out_ready && (sel == 1'b1);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= arb_idle;
      served <= 1'b1; // So port 0 goes first.
    end else begin
      case (state)
        arb_idle: begin
          if (out_valid) begin
            served <= sel; // Grant locks on the first beat.
            if (!xfer_last) begin
              state <= arb_busy;
            end
          end
        end
        arb_busy: begin
          if (xfer_last) begin
            state <= arb_idle;
          end
        end
        default: begin
          state <= arb_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/frame_stats.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_stats import mux_pkg::*; #(
  parameter int STAT_WIDTH = stat_w
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        commit [2],
  input  logic        drop [2],
  output port_stats_t stats [2]
);

  logic [STAT_WIDTH-1:0] n_commit [2];
  logic [STAT_WIDTH-1:0] n_drop [2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2; i++) begin
        n_commit[i] <= '0;
        n_drop[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (commit[i] && (n_commit[i] != '1)) begin
          n_commit[i] <= n_commit[i] + 1'b1; // Sticks at max.
        end
        if (drop[i] && (n_drop[i] != '1)) begin
          n_drop[i] <= n_drop[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      stats[i].committed = n_commit[i];
      stats[i].dropped   = n_drop[i];
    end
  end

endmodule

`default_nettype wire

// ==== design/frame_mux_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_mux_top import axis_pkg::*, mux_pkg::*; #(
  parameter int ADDR_WIDTH = 3,
  parameter int DATA_WIDTH = axis_data_w, // Must match the package types.
  parameter int STAT_WIDTH = stat_w
) (
  input  logic        clk,
  input  logic        rst,
  input  axis_in_t    in_beat [2],
  input  logic        in_valid [2],
  output logic        in_ready [2],
  output axis_out_t   out_beat,
  output logic        out_valid,
  input  logic        out_ready,
  output port_stats_t stats [2]
);

  fifo_beat_t fifo_beat [2];
  logic       fifo_valid [2];
  logic       fifo_ready [2];
  logic       commit [2];
  logic       drop [2];

  for (genvar i = 0; i < 2; i++) begin : g_port
    axis_frame_fifo #(
      .ADDR_WIDTH(ADDR_WIDTH),
      .DATA_WIDTH(DATA_WIDTH)
    ) u_fifo (
      .clk       (clk),
      .rst       (rst),
      .in_beat   (in_beat[i]),
      .in_valid  (in_valid[i]),
      .in_ready  (in_ready[i]),
      .fifo_beat (fifo_beat[i]),
      .fifo_valid(fifo_valid[i]),
      .fifo_ready(fifo_ready[i]),
      .commit    (commit[i]),
      .drop      (drop[i])
    );
  end

  frame_arbiter #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .fifo_beat (fifo_beat),
    .fifo_valid(fifo_valid),
    .fifo_ready(fifo_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  frame_stats #(
    .STAT_WIDTH(STAT_WIDTH)
  ) u_stats (
    .clk   (clk),
    .rst   (rst),
    .commit(commit),
    .drop  (drop),
    .stats (stats)
  );

endmodule

`default_nettype wire

// ==== dv/tb_frame_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_frame_mux import axis_pkg::*, mux_pkg::*; ();

  localparam int ADDR_WIDTH = 3;
  localparam int DEPTH      = 2**ADDR_WIDTH;

  logic        clk;
  logic        rst;
  axis_in_t    in_beat [2];
  logic        in_valid [2];
  logic        in_ready [2];
  axis_out_t   out_beat;
  logic        out_valid;
  logic        out_ready;
  port_stats_t stats [2];

  axis_out_t   exp_q [2][$];   // Committed beats still owed by each port.
  int          ready_cyc [2];  // Cycle from which the queued frame is visible to the arbiter.
  port_stats_t model_stats [2];
  int          cyc;
  logic        hold_low;
  logic        locked;         // A frame is granted and not yet finished.
  logic        lock_src;
  logic        last_src;
  logic        rst_d1;
  logic        rst_d2;

  frame_mux_top #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_beat (out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .stats    (stats)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("FAILED at %0d ns: %s", $time, msg));
  endtask

  task automatic check_beat(input axis_out_t got, input axis_out_t want);
    if (got !== want) begin
      report_mismatch($sformatf("egress beat %h, expected %h", got, want));
    end
  endtask

  task automatic check_stats(input port_stats_t got, input port_stats_t want, input int p);
    if (got !== want) begin
      report_mismatch($sformatf("port %0d stats committed %0d dropped %0d, expected %0d and %0d",
                                p, got.committed, got.dropped, want.committed, want.dropped));
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      report_mismatch($sformatf("%s is %b, expected %b", what, got, want));
    end
  endtask

  function automatic bit frame_visible(input logic p);
    return (exp_q[p].size() != 0) && (cyc >= ready_cyc[p]);
  endfunction

  task automatic wait_port_idle(input int p);
    int t;
    t = 0;
    while (exp_q[p].size() != 0) begin
      @(posedge clk);
      #1;
      t++;
      if (t > 2000) begin
        abort_run($sformatf("Timeout: a frame of port %0d never left the egress", p));
      end
    end
  endtask

  // Called 1 ns after a rising edge; returns at the same phase.
  task automatic send_frame(input int p, input int len, input bit err);
    axis_out_t   beats [$];
    logic [31:0] r;
    bit          keep;
    keep = !err && (len <= DEPTH); // Clean and fits the buffer.
    for (int i = 0; i < len; i++) begin
      r = $urandom;
      in_beat[p]  = '{data: r[axis_data_w-1:0], last: (i == len - 1),
                      user: err && (i == len - 1)};
      in_valid[p] = 1'b1;
      beats.push_back('{data: r[axis_data_w-1:0], last: (i == len - 1), src: p[0]});
      if (i == len - 1) begin
        if (keep) begin
          ready_cyc[p] = cyc + 2;
          foreach (beats[k]) exp_q[p].push_back(beats[k]);
          model_stats[p].committed = model_stats[p].committed + 1'b1;
        end else begin
          model_stats[p].dropped = model_stats[p].dropped + 1'b1;
        end
      end
      @(posedge clk);
      #1;
      check_flag(in_ready[p], 1'b1, "in_ready");
    end
    in_valid[p] = 1'b0;
    @(posedge clk); // Pulse has reached the counter.
    #1;
    check_stats(stats[p], model_stats[p], p);
  endtask

  task automatic run_port(input int p, input int frames);
    int gap;
    int len;
    bit err;
    for (int f = 0; f < frames; f++) begin
      wait_port_idle(p);
      gap = $urandom_range(0, 3);
      for (int g = 0; g < gap; g++) begin
        @(posedge clk);
        #1;
      end
      len = $urandom_range(1, 12);
      err = ($urandom_range(0, 4) == 0);
      send_frame(p, len, err);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Samples the egress mid-cycle when everything has settled.
  always @(negedge clk) begin
    axis_out_t want;
    logic      grant;
    if (rst || rst_d1 || rst_d2) begin
      check_flag(out_valid, 1'b0, "out_valid near reset");
    end else if (out_valid) begin
      if (!locked) begin
        grant = last_src;
        if (frame_visible(!last_src)) begin
          grant = !last_src; // Round robin favours the port not served last.
        end
        check_flag(out_beat.src, grant, "granted port");
        locked   = 1'b1;
        lock_src = grant;
      end else if (out_beat.src !== lock_src) begin
        report_mismatch("frames of both ports interleaved");
      end
      if (out_ready) begin
        if (exp_q[out_beat.src].size() == 0) begin
          report_mismatch($sformatf("beat from port %0d with no committed frame",
                                    out_beat.src));
        end
        want = exp_q[out_beat.src].pop_front();
        check_beat(out_beat, want);
        if (out_beat.last) begin
          locked   = 1'b0;
          last_src = out_beat.src;
        end
      end
    end
    rst_d2 = rst_d1;
    rst_d1 = rst;
  end

  // Random back-pressure with occasional long stalls.
  initial begin
    int low_left;
    low_left = 0;
    forever begin
      @(posedge clk);
      #1;
      if (rst || hold_low || low_left > 0) begin
        out_ready = 1'b0;
        if (low_left > 0) low_left--;
      end else begin
        out_ready = ($urandom_range(0, 3) != 0);
        if ($urandom_range(0, 63) == 0) low_left = 25;
      end
    end
  end

  initial begin
    void'($urandom(96991));
    rst         = 1'b1;
    out_ready   = 1'b0;
    hold_low    = 1'b0;
    in_valid[0] = 1'b0;
    in_valid[1] = 1'b0;
    in_beat[0]  = '0;
    in_beat[1]  = '0;
    cyc         = 0;
    locked      = 1'b0;
    lock_src    = 1'b0;
    last_src    = 1'b1; // Reset marks port 1 as served.
    rst_d1      = 1'b1;
    rst_d2      = 1'b1;
    ready_cyc   = '{0, 0};
    model_stats = '{'0, '0};
    repeat (8) @(posedge clk);
    #1;
    rst      = 1'b0;
    hold_low = 1'b1;
    // Overflow and error frames on a stalled egress followed by short ones.
    fork
      begin
        send_frame(0, 12, 1'b0);
        wait_port_idle(0);
        send_frame(0, 5, 1'b0);
      end
      begin
        send_frame(1, 10, 1'b0);
        send_frame(1, 3, 1'b1);
        send_frame(1, 6, 1'b0);
      end
    join
    hold_low = 1'b0;
    wait_port_idle(0);
    wait_port_idle(1);
    // Port 0 was served last, so a tie must go to port 1.
    send_frame(0, 2, 1'b0);
    wait_port_idle(0);
    fork
      send_frame(0, 4, 1'b0);
      send_frame(1, 4, 1'b0);
    join
    fork
      run_port(0, 40);
      run_port(1, 40);
    join
    wait_port_idle(0);
    wait_port_idle(1);
    repeat (2) @(posedge clk);
    #1;
    check_stats(stats[0], model_stats[0], 0);
    check_stats(stats[1], model_stats[1], 1);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/axis_pkg.sv
design/mux_pkg.sv
design/axis_frame_fifo.sv
design/frame_arbiter.sv
design/frame_stats.sv
design/frame_mux_top.sv
dv/tb_frame_mux.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/10ps -f list.f \
  --top-module tb_frame_mux -o sim_tb_frame_mux &&
./obj_dir/sim_tb_frame_mux || exit 1
